/* src/lvds_rx_config.svh */
`ifndef LVDS_RX_CONFIG_SVH
`define LVDS_RX_CONFIG_SVH

// number of receive lanes
`define LVDS_RX_LANES 4

// bits per deserialized word
`define LVDS_RX_WORD_BITS 8

// interval counter width, top bit ends the long waits
`define LVDS_RX_CNT_BITS 10

// counter bit ending the short settle windows
`define LVDS_RX_SETTLE_BIT 4

// word sent during training, all rotations distinct
`define LVDS_RX_TRAIN_PATTERN 8'h1F

`endif

/* src/lvds_rx_pkg.sv */
`include "lvds_rx_config.svh"

package lvds_rx_pkg;

    // calibration controller states
    typedef enum logic [2:0] {
        CAL_WAIT_IDLE   = 3'd0,
        CAL_INIT_REQ    = 3'd1,
        CAL_INIT_WAIT   = 3'd2,
        CAL_PERIOD_WAIT = 3'd3,
        CAL_PRE_MASK    = 3'd4,
        CAL_SLAVE_REQ   = 3'd5,
        CAL_SLAVE_WAIT  = 3'd6,
        CAL_POST_SETTLE = 3'd7
    } cal_state_e;

    // common controls for all delay elements
    typedef struct packed {
        logic rst;
        logic mask;
        logic cal;
        logic cal_master;
    } iod_ctrl_t;

    // one word per lane, for input and output side
    typedef logic [`LVDS_RX_LANES-1:0][`LVDS_RX_WORD_BITS-1:0] lane_words_t;

    // word plus its valid flag inside a lane pipeline
    typedef struct packed {
        logic                          valid;
        logic [`LVDS_RX_WORD_BITS-1:0] word;
    } lane_beat_t;

endpackage

/* src/iod_cal_ctrl.sv */
`include "lvds_rx_config.svh"

module iod_cal_ctrl
    import lvds_rx_pkg::*;
(
    input  logic                      clk_div,
    input  logic                      rst,
    input  logic [`LVDS_RX_LANES-1:0] iod_busy,
    output iod_ctrl_t                 iod_ctrl,
    output logic                      rdy
);

    localparam int CNT_BITS   = `LVDS_RX_CNT_BITS;
    localparam int SETTLE_BIT = `LVDS_RX_SETTLE_BIT;

    logic [`LVDS_RX_LANES-1:0] busy_q;
    logic                      any_busy;
    logic                      all_busy;

    logic [CNT_BITS-1:0]       cnt;
    logic                      cnt_clr;
    logic                      cnt_top;
    logic                      cnt_settle;

    cal_state_e                state;

    // busy comes straight from the delay primitives, cut the path here
    always_ff @(posedge clk_div or posedge rst) begin
        if (rst) begin
            busy_q <= '0;
        end else begin
            busy_q <= iod_busy;
        end
    end

    assign any_busy = |busy_q;
    assign all_busy = &busy_q;

    assign cnt_top    = cnt[CNT_BITS-1];
    assign cnt_settle = cnt[SETTLE_BIT];

    // interval counter, wraps itself at the top bit
    always_ff @(posedge clk_div or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (cnt_clr || cnt_top) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_div or posedge rst) begin
        if (rst) begin
            state               <= CAL_WAIT_IDLE;
            cnt_clr             <= 1'b1;
            iod_ctrl.rst        <= 1'b1;
            iod_ctrl.mask       <= 1'b1;
            iod_ctrl.cal        <= 1'b0;
            iod_ctrl.cal_master <= 1'b0;
            rdy                 <= 1'b0;
        end else begin
            // defaults, each state raises what it needs
            cnt_clr             <= 1'b1;
            iod_ctrl.rst        <= 1'b0;
            iod_ctrl.mask       <= 1'b0;
            iod_ctrl.cal        <= 1'b0;
            iod_ctrl.cal_master <= 1'b0;

            case (state)
                // let the delay elements come out of power-up
                CAL_WAIT_IDLE: begin
                    cnt_clr       <= 1'b0;
                    iod_ctrl.mask <= 1'b1;
                    if (cnt_top && !any_busy) begin
                        state <= CAL_INIT_REQ;
                    end
                end

                // master calibration, hold request until every lane takes it
                CAL_INIT_REQ: begin
                    iod_ctrl.mask       <= 1'b1;
                    iod_ctrl.cal        <= 1'b1;
                    iod_ctrl.cal_master <= 1'b1;
                    if (all_busy) begin
                        iod_ctrl.cal        <= 1'b0;
                        iod_ctrl.cal_master <= 1'b0;
                        state               <= CAL_INIT_WAIT;
                    end
                end

                // done when all lanes idle, then one reset pulse
                CAL_INIT_WAIT: begin
                    iod_ctrl.mask <= 1'b1;
                    if (!any_busy) begin
                        iod_ctrl.rst <= 1'b1;
                        state        <= CAL_PERIOD_WAIT;
                    end
                end

                // normal traffic between calibrations
                CAL_PERIOD_WAIT: begin
                    cnt_clr <= 1'b0;
                    if (cnt_top) begin
                        state <= CAL_PRE_MASK;
                    end
                end

                // mask ahead of the slave request
                // window restarts while any lane is still busy
                CAL_PRE_MASK: begin
                    cnt_clr       <= any_busy;
                    iod_ctrl.mask <= 1'b1;
                    if (cnt_settle) begin
                        state <= CAL_SLAVE_REQ;
                    end
                end

                CAL_SLAVE_REQ: begin
                    iod_ctrl.mask <= 1'b1;
                    iod_ctrl.cal  <= 1'b1;
                    if (all_busy) begin
                        iod_ctrl.cal <= 1'b0;
                        state        <= CAL_SLAVE_WAIT;
                    end
                end

                CAL_SLAVE_WAIT: begin
                    iod_ctrl.mask <= 1'b1;
                    if (!any_busy) begin
                        state <= CAL_POST_SETTLE;
                    end
                end

                // keep data masked a little longer after calibration
                CAL_POST_SETTLE: begin
                    cnt_clr       <= 1'b0;
                    iod_ctrl.mask <= 1'b1;
                    if (cnt_settle) begin
                        // first finished slave calibration makes the link ready
                        rdy   <= 1'b1;
                        state <= CAL_PERIOD_WAIT;
                    end
                end

                default: begin
                    state <= CAL_WAIT_IDLE;
                end
            endcase
        end
    end

    // data must never be unmasked while a calibration is requested
    a_cal_masked: assert property (@(posedge clk_div) disable iff (rst)
        iod_ctrl.cal |-> iod_ctrl.mask);

    a_master_in_cal: assert property (@(posedge clk_div) disable iff (rst)
        iod_ctrl.cal_master |-> iod_ctrl.cal);

    // ready is sticky until reset
    a_rdy_sticky: assert property (@(posedge clk_div) disable iff (rst)
        rdy |=> rdy);

    // delay element reset is a single-cycle pulse
    a_rst_pulse: assert property (@(posedge clk_div) disable iff (rst)
        iod_ctrl.rst |=> !iod_ctrl.rst);

endmodule

/* src/lane_align.sv */
`include "lvds_rx_config.svh"

module lane_align
    import lvds_rx_pkg::*;
(
    input  logic                          clk_div,
    input  logic                          rst,
    input  logic [`LVDS_RX_WORD_BITS-1:0] word,
    input  logic                          mask,
    input  logic                          rdy,
    input  logic                          train,
    output logic [`LVDS_RX_WORD_BITS-1:0] out_word,
    output logic                          out_valid,
    output logic                          aligned
);

    localparam int W         = `LVDS_RX_WORD_BITS;
    localparam int SLIP_BITS = (W > 1) ? $clog2(W) : 1;

    localparam logic [W-1:0]         TRAIN_WORD = `LVDS_RX_TRAIN_PATTERN;
    localparam logic [SLIP_BITS-1:0] SLIP_LAST  = SLIP_BITS'(W - 1);

    lane_beat_t           s1;
    logic [SLIP_BITS-1:0] slip;
    logic [2*W-1:0]       rot_wide;
    logic [W-1:0]         rot_word;
    logic                 pattern_hit;

    // stage one captures the word with the valid condition of its cycle
    always_ff @(posedge clk_div or posedge rst) begin
        if (rst) begin
            s1 <= '0;
        end else begin
            s1.valid <= rdy & ~mask;
            s1.word  <= word;
        end
    end

    // rotate left by slip through the upper half of the doubled word
    assign rot_wide    = {s1.word, s1.word} << slip;
    assign rot_word    = rot_wide[2*W-1:W];
    assign pattern_hit = (rot_word == TRAIN_WORD);

    // slip search only runs on valid training words
    always_ff @(posedge clk_div or posedge rst) begin
        if (rst) begin
            slip <= '0;
        end else if (train && s1.valid && !pattern_hit) begin
            if (slip == SLIP_LAST) begin
                slip <= '0;
            end else begin
                slip <= slip + 1'b1;
            end
        end
    end

    // stage two output word
    always_ff @(posedge clk_div) begin
        out_word <= rot_word;
    end

    always_ff @(posedge clk_div or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            aligned   <= 1'b0;
        end else begin
            out_valid <= s1.valid;
            // aligned follows the last training compare
            if (train && s1.valid) begin
                aligned <= pattern_hit;
            end
        end
    end

    // masked input may not reach the output two cycles later
    a_mask_gates_valid: assert property (@(posedge clk_div) disable iff (rst)
        mask |=> ##1 !out_valid);

endmodule

/* src/lvds_rx_top.sv */
`include "lvds_rx_config.svh"

module lvds_rx_top
    import lvds_rx_pkg::*;
(
    input  logic                      clk_div,
    input  logic                      rst,

    // delay element status per lane
    input  logic [`LVDS_RX_LANES-1:0] iod_busy,

    // one deserialized word per lane per cycle
    input  lane_words_t               rx_words,

    // sender is transmitting the training word
    input  logic                      train,

    output iod_ctrl_t                 iod_ctrl,
    output logic                      rdy,

    output lane_words_t               out_words,
    output logic [`LVDS_RX_LANES-1:0] out_valid,
    output logic [`LVDS_RX_LANES-1:0] aligned
);

    localparam int LANES = `LVDS_RX_LANES;

    // shared calibration controller
    iod_cal_ctrl u_cal_ctrl (
        .clk_div  (clk_div),
        .rst      (rst),
        .iod_busy (iod_busy),
        .iod_ctrl (iod_ctrl),
        .rdy      (rdy)
    );

    // per-lane word alignment
    // all lanes see the common mask and ready
    for (genvar g = 0; g < LANES; g++) begin : g_lane
        lane_align u_lane (
            .clk_div   (clk_div),
            .rst       (rst),
            .word      (rx_words[g]),
            .mask      (iod_ctrl.mask),
            .rdy       (rdy),
            .train     (train),
            .out_word  (out_words[g]),
            .out_valid (out_valid[g]),
            .aligned   (aligned[g])
        );
    end

endmodule

/* test/tb_lvds_rx.sv */
`include "lvds_rx_config.svh"

module tb_lvds_rx
    import lvds_rx_pkg::*;
();

    localparam int LANES      = `LVDS_RX_LANES;
    localparam int W          = `LVDS_RX_WORD_BITS;
    localparam int CNT_BITS   = `LVDS_RX_CNT_BITS;
    localparam int SETTLE_BIT = `LVDS_RX_SETTLE_BIT;
    localparam int WAIT_LIMIT = 5000;

    localparam logic [W-1:0] PATTERN = `LVDS_RX_TRAIN_PATTERN;

    logic             clk_div;
    logic             rst;
    logic [LANES-1:0] iod_busy;
    lane_words_t      rx_words;
    logic             train;
    iod_ctrl_t        iod_ctrl;
    logic             rdy;
    lane_words_t      out_words;
    logic [LANES-1:0] out_valid;
    logic [LANES-1:0] aligned;

    // controller model
    cal_state_e          m_state;
    cal_state_e          m_prev_state;
    logic [CNT_BITS-1:0] m_cnt;
    logic                m_clr;
    logic [LANES-1:0]    m_busy_q;
    iod_ctrl_t           m_ctrl;
    logic                m_rdy;

    // lane model
    logic [LANES-1:0] m_s1_valid;
    logic [W-1:0]     m_s1_word [LANES];
    int               m_slip [LANES];
    logic [LANES-1:0] m_out_valid;
    logic [LANES-1:0] m_aligned;
    logic [W-1:0]     m_out_word [LANES];

    // delay element busy model
    int wait_cnt [LANES];
    int hold_len [LANES];
    int busy_left [LANES];
    int spont_left [LANES];

    int   train_rot [LANES];
    logic train_req;
    logic pattern_req;

    int   errors;
    int   failures;
    int   cal_rises;
    int   rst_pulses;
    int   pre_len;
    logic cal_rose;
    logic prev_cal;
    logic prev_rdy;
    logic spont_in_pre;
    logic timed_out;

    initial clk_div = 1'b0;
    always #10 clk_div = ~clk_div;

    lvds_rx_top dut (
        .clk_div   (clk_div),
        .rst       (rst),
        .iod_busy  (iod_busy),
        .rx_words  (rx_words),
        .train     (train),
        .iod_ctrl  (iod_ctrl),
        .rdy       (rdy),
        .out_words (out_words),
        .out_valid (out_valid),
        .aligned   (aligned)
    );

    // bit i moves to position i + s
    function automatic logic [W-1:0] rotl(input logic [W-1:0] v, input int s);
        logic [W-1:0] r;
        for (int i = 0; i < W; i++) begin
            r[(i + s) % W] = v[i];
        end
        return r;
    endfunction

    task automatic ctrl_model_step(input logic [LANES-1:0] busy_in);
        cal_state_e          nxt;
        iod_ctrl_t           c;
        logic                clr;
        logic                any_b;
        logic                all_b;
        logic                top;
        logic                settle;
        logic [CNT_BITS-1:0] cnt_n;
        any_b  = |m_busy_q;
        all_b  = &m_busy_q;
        top    = m_cnt[CNT_BITS-1];
        settle = m_cnt[SETTLE_BIT];
        cnt_n  = (m_clr || top) ? '0 : m_cnt + 1'b1;
        nxt    = m_state;
        clr    = 1'b1;
        c      = '0;
        case (m_state)
            CAL_WAIT_IDLE: begin
                clr    = 1'b0;
                c.mask = 1'b1;
                if (top && !any_b)
                    nxt = CAL_INIT_REQ;
            end
            CAL_INIT_REQ: begin
                c.mask = 1'b1;
                if (all_b) begin
                    nxt = CAL_INIT_WAIT;
                end else begin
                    c.cal        = 1'b1;
                    c.cal_master = 1'b1;
                end
            end
            CAL_INIT_WAIT: begin
                c.mask = 1'b1;
                if (!any_b) begin
                    c.rst = 1'b1;
                    nxt   = CAL_PERIOD_WAIT;
                end
            end
            CAL_PERIOD_WAIT: begin
                clr = 1'b0;
                if (top)
                    nxt = CAL_PRE_MASK;
            end
            CAL_PRE_MASK: begin
                clr    = any_b;
                c.mask = 1'b1;
                if (settle)
                    nxt = CAL_SLAVE_REQ;
            end
            CAL_SLAVE_REQ: begin
                c.mask = 1'b1;
                c.cal  = !all_b;
                if (all_b)
                    nxt = CAL_SLAVE_WAIT;
            end
            CAL_SLAVE_WAIT: begin
                c.mask = 1'b1;
                if (!any_b)
                    nxt = CAL_POST_SETTLE;
            end
            default: begin
                clr    = 1'b0;
                c.mask = 1'b1;
                if (settle) begin
                    m_rdy = 1'b1;
                    nxt   = CAL_PERIOD_WAIT;
                end
            end
        endcase
        m_prev_state = m_state;
        m_state      = nxt;
        m_cnt        = cnt_n;
        m_clr        = clr;
        m_ctrl       = c;
        m_busy_q     = busy_in;
    endtask

    // uses mask and rdy from before the edge, so it runs ahead of the controller
    task automatic lane_model_step(input lane_words_t words, input logic trn);
        logic [W-1:0] rot;
        logic         hit;
        for (int i = 0; i < LANES; i++) begin
            rot            = rotl(m_s1_word[i], m_slip[i]);
            hit            = (rot == PATTERN);
            m_out_word[i]  = rot;
            m_out_valid[i] = m_s1_valid[i];
            if (trn && m_s1_valid[i]) begin
                m_aligned[i] = hit;
                if (!hit)
                    m_slip[i] = (m_slip[i] + 1) % W;
            end
            m_s1_valid[i] = m_rdy & ~m_ctrl.mask;
            m_s1_word[i]  = words[i];
        end
    endtask

    task automatic check_reset_outputs();
        assert (iod_ctrl.rst && iod_ctrl.mask && !iod_ctrl.cal && !iod_ctrl.cal_master && !rdy)
        else begin
            errors++;
            $display("MISMATCH at %0t: reset outputs ctrl %b rdy %b", $time, iod_ctrl, rdy);
        end
    endtask

    task automatic check_outputs();
        assert (iod_ctrl == m_ctrl) else begin
            errors++;
            $display("MISMATCH at %0t: iod_ctrl %b, expected %b", $time, iod_ctrl, m_ctrl);
        end
        assert (rdy == m_rdy) else begin
            errors++;
            $display("MISMATCH at %0t: rdy %b, expected %b", $time, rdy, m_rdy);
        end
        assert (out_valid == m_out_valid) else begin
            errors++;
            $display("MISMATCH at %0t: out_valid %b, expected %b", $time, out_valid, m_out_valid);
        end
        assert (aligned == m_aligned) else begin
            errors++;
            $display("MISMATCH at %0t: aligned %b, expected %b", $time, aligned, m_aligned);
        end
        for (int i = 0; i < LANES; i++) begin
            if (m_out_valid[i])
                assert (out_words[i] == m_out_word[i]) else begin
                    errors++;
                    $display("MISMATCH at %0t: lane %0d word %h, expected %h",
                             $time, i, out_words[i], m_out_word[i]);
                end
        end
        cal_rose = iod_ctrl.cal && !prev_cal;
        if (cal_rose)
            cal_rises++;
        if (iod_ctrl.rst)
            rst_pulses++;
        // master calibration belongs to the first request only
        if (iod_ctrl.cal_master)
            assert (cal_rises == 1) else begin
                errors++;
                $display("cal_master high at %0t outside the first calibration", $time);
            end
        if (rdy && !prev_rdy)
            assert (m_prev_state == CAL_POST_SETTLE && cal_rises == 2) else begin
                errors++;
                $display("rdy rose at %0t outside the first post-calibration settle", $time);
            end
        assert (!(prev_rdy && !rdy)) else begin
            errors++;
            $display("rdy fell at %0t without reset", $time);
        end
        // a busy lane during the pre-mask window has to stretch it
        if (m_state == CAL_PRE_MASK) begin
            pre_len++;
        end else if (m_prev_state == CAL_PRE_MASK) begin
            if (spont_in_pre)
                assert (pre_len > (1 << SETTLE_BIT) + 2) else begin
                    errors++;
                    $display("busy in pre-mask at %0t did not delay the request", $time);
                end
            pre_len      = 0;
            spont_in_pre = 1'b0;
        end
        prev_cal = iod_ctrl.cal;
        prev_rdy = rdy;
    endtask

    task automatic drive_inputs();
        int               lane;
        logic [LANES-1:0] b;
        if (m_state == CAL_PRE_MASK && m_prev_state != CAL_PRE_MASK) begin
            lane             = $urandom_range(0, LANES - 1);
            spont_left[lane] = $urandom_range(2, 10);
            spont_in_pre     = 1'b1;
        end else if (m_state == CAL_PERIOD_WAIT && $urandom_range(0, 299) == 0) begin
            lane             = $urandom_range(0, LANES - 1);
            spont_left[lane] = $urandom_range(2, 10);
        end
        for (int i = 0; i < LANES; i++) begin
            if (cal_rose) begin
                wait_cnt[i] = $urandom_range(1, 3);
                hold_len[i] = $urandom_range(5, 30);
            end
            if (wait_cnt[i] > 0) begin
                wait_cnt[i]--;
                if (wait_cnt[i] == 0)
                    busy_left[i] = hold_len[i];
            end
            b[i] = (busy_left[i] > 0) || (spont_left[i] > 0);
            if (busy_left[i] > 0)
                busy_left[i]--;
            if (spont_left[i] > 0)
                spont_left[i]--;
            if (pattern_req)
                rx_words[i] = rotl(PATTERN, (W - train_rot[i]) % W);
            else
                rx_words[i] = W'($urandom);
        end
        iod_busy = b;
        train    = train_req;
    endtask

    // sample just after the edge, drive a little later
    task automatic run_cycle();
        @(posedge clk_div);
        #1;
        lane_model_step(rx_words, train);
        ctrl_model_step(iod_busy);
        check_outputs();
        #1;
        drive_inputs();
    endtask

    initial begin
        int   n;
        int   valid_cnt [LANES];
        logic [LANES-1:0] al_done;
        void'($urandom(32'h89e6bb8e));
        rst      = 1'b1;
        iod_busy = '0;
        rx_words = '0;
        train    = 1'b0;
        {train_req, pattern_req, cal_rose, prev_cal, prev_rdy} = '0;
        {spont_in_pre, timed_out} = '0;
        {errors, failures, cal_rises, rst_pulses, pre_len} = '0;
        m_state      = CAL_WAIT_IDLE;
        m_prev_state = CAL_WAIT_IDLE;
        m_cnt        = '0;
        m_clr        = 1'b1;
        m_busy_q     = '0;
        m_ctrl       = '0;
        m_ctrl.rst   = 1'b1;
        m_ctrl.mask  = 1'b1;
        m_rdy        = 1'b0;
        m_s1_valid   = '0;
        m_out_valid  = '0;
        m_aligned    = '0;
        for (int i = 0; i < LANES; i++) begin
            m_s1_word[i] = '0;
            m_slip[i]    = 0;
            {wait_cnt[i], hold_len[i], busy_left[i], spont_left[i]} = '0;
            {train_rot[i], valid_cnt[i]} = '0;
        end
        repeat (10) begin
            @(posedge clk_div);
            #1;
            check_reset_outputs();
        end
        #1;
        rst = 1'b0;
        #1;
        check_reset_outputs();

        // power-up wait, master calibration and first slave calibration
        n = 0;
        while (!rdy && n < WAIT_LIMIT) begin
            run_cycle();
            n++;
        end
        if (!rdy) begin
            failures++;
            $display("timed out waiting for rdy after the initial calibration");
            timed_out = 1'b1;
        end

        // word alignment on the training pattern
        if (!timed_out) begin
            for (int i = 0; i < LANES; i++)
                train_rot[i] = $urandom_range(0, W - 1);
            pattern_req = 1'b1;
            run_cycle();
            train_req = 1'b1;
            al_done   = '0;
            n         = 0;
            while (al_done != '1 && n < 4 * W) begin
                run_cycle();
                n++;
                for (int i = 0; i < LANES; i++) begin
                    if (out_valid[i])
                        valid_cnt[i]++;
                    if (aligned[i] && !al_done[i]) begin
                        al_done[i] = 1'b1;
                        assert (valid_cnt[i] <= W) else begin
                            errors++;
                            $display("lane %0d took %0d valid words to align", i, valid_cnt[i]);
                        end
                        assert (out_words[i] == PATTERN) else begin
                            errors++;
                            $display("MISMATCH at %0t: lane %0d aligned word %h",
                                     $time, i, out_words[i]);
                        end
                    end
                end
            end
            if (al_done != '1) begin
                failures++;
                $display("timed out waiting for all lanes to align");
                timed_out = 1'b1;
            end
            repeat (8) run_cycle();
            train_req   = 1'b0;
            pattern_req = 1'b0;
        end

        // random traffic across further periodic calibrations
        if (!timed_out) begin
            n = 0;
            while ((cal_rises < 5 || iod_ctrl.mask) && n < 4 * WAIT_LIMIT) begin
                run_cycle();
                n++;
            end
            if (cal_rises < 5 || iod_ctrl.mask) begin
                failures++;
                $display("timed out waiting for the periodic calibrations");
                timed_out = 1'b1;
            end
            assert (rst_pulses == 1) else begin
                errors++;
                $display("delay element reset pulsed %0d times, expected once", rst_pulses);
            end
        end

        $display("checks failed: %0d, timeouts: %0d", errors, failures);
        if (errors == 0 && failures == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

/* lvds_rx.f */
+incdir+src
src/lvds_rx_pkg.sv
src/iod_cal_ctrl.sv
src/lane_align.sv
src/lvds_rx_top.sv
test/tb_lvds_rx.sv

/* build.sh */
#!/bin/sh
# compile the testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_lvds_rx \
    -Mdir obj_dir \
    -f lvds_rx.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_lvds_rx)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
